// ==== verilog/frontend_pkg.sv ====
package frontend_pkg;

  // Fetch
  localparam logic [31:0] RESET_PC = 32'h1c00_0000;
  localparam int unsigned QUEUE_DEPTH = 16;

  // Register-select codes per read and write port
  localparam logic [1:0] R0_NONE = 2'd0;
  localparam logic [1:0] R0_RK   = 2'd1;
  localparam logic [1:0] R0_RD   = 2'd2;

  localparam logic [1:0] R1_NONE = 2'd0;
  localparam logic [1:0] R1_RJ   = 2'd1;

  localparam logic [1:0] W_NONE  = 2'd0;
  localparam logic [1:0] W_RD    = 2'd1;
  localparam logic [1:0] W_LINK  = 2'd2;

  // One fetched word and its address
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_entry_t;

  // Taken from inst[31:30]
  typedef enum logic [1:0] {
    CLS_ALU_RR = 2'b00,
    CLS_ALU_RI = 2'b01,
    CLS_STORE  = 2'b10,
    CLS_BRANCH = 2'b11
  } inst_class_t;

  typedef struct packed {
    logic [31:0] pc;
    inst_class_t cls;
    logic        is_link;
    logic [4:0]  r_reg0;
    logic [4:0]  r_reg1;
    logic [4:0]  w_reg;
    logic [25:0] imm;
  } decoded_inst_t;

endpackage

// ==== verilog/fetch_wr_if.sv ====
`timescale 1ns/1ps

interface fetch_wr_if import frontend_pkg::*; ();

  logic               valid;
  logic [1:0]         num;
  // Entry 0 is first in program order
  fetch_entry_t [1:0] data;
  logic               ready;

  modport producer (
    output valid,
    output num,
    output data,
    input  ready
  );

  modport queue (
    input  valid,
    input  num,
    input  data,
    output ready
  );

endinterface

// ==== verilog/fetch_pc_gen.sv ====
`timescale 1ns/1ps

module fetch_pc_gen import frontend_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             redirect_i,
  input  logic [31:0]      redirect_pc_i,
  input  logic             wait_inst_i,
  input  logic             int_i,
  input  logic             imem_valid_i,
  input  logic [1:0][31:0] imem_data_i,
  output logic             imem_req_o,
  output logic [31:0]      imem_addr_o,
  fetch_wr_if.producer     wr
);

  logic [31:0]        fetch_pc;
  logic [31:0]        req_pc;
  logic               req_q;
  logic               pending;
  logic               stale;
  logic               idle_lock;
  logic               wr_valid;
  logic [1:0]         wr_num;
  fetch_entry_t [1:0] wr_data;
  logic               can_req;
  logic               resp_ok;

  // Room must already be reserved when a request leaves
  assign can_req = !pending && !wr_valid && wr.ready && !idle_lock && !redirect_i;
  assign resp_ok = imem_valid_i && pending && !stale && !redirect_i;

  assign imem_req_o  = req_q;
  assign imem_addr_o = {req_pc[31:3], 3'b000};

  assign wr.valid = wr_valid;
  assign wr.num   = wr_num;
  assign wr.data  = wr_data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fetch_pc  <= RESET_PC;
      req_q     <= 1'b0;
      pending   <= 1'b0;
      stale     <= 1'b0;
      idle_lock <= 1'b0;
      wr_valid  <= 1'b0;
    end else begin
      req_q    <= can_req;
      wr_valid <= resp_ok;
      if (wait_inst_i && !int_i) begin
        idle_lock <= 1'b1;
      end else if (int_i) begin
        idle_lock <= 1'b0;
      end
      if (redirect_i) begin
        fetch_pc <= redirect_pc_i;
        // In-flight response gets dropped on arrival
        pending  <= pending && !imem_valid_i;
        stale    <= pending && !imem_valid_i;
      end else if (pending && imem_valid_i) begin
        pending <= 1'b0;
        stale   <= 1'b0;
      end else if (can_req) begin
        pending  <= 1'b1;
        fetch_pc <= {fetch_pc[31:3], 3'b000} + 32'd8;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (can_req) begin
      req_pc <= fetch_pc;
    end
    if (resp_ok) begin
      wr_data[1].pc   <= {req_pc[31:3], 3'b100};
      wr_data[1].inst <= imem_data_i[1];
      // Odd start keeps only the upper word
      if (req_pc[2]) begin
        wr_num          <= 2'd1;
        wr_data[0].pc   <= {req_pc[31:3], 3'b100};
        wr_data[0].inst <= imem_data_i[1];
      end else begin
        wr_num          <= 2'd2;
        wr_data[0].pc   <= {req_pc[31:3], 3'b000};
        wr_data[0].inst <= imem_data_i[0];
      end
    end
  end

endmodule

// ==== verilog/inst_queue.sv ====
`timescale 1ns/1ps

module inst_queue import frontend_pkg::*; #(
  parameter type         T     = fetch_entry_t,
  parameter int unsigned DEPTH = QUEUE_DEPTH
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       flush_i,
  input  logic [1:0] read_num_i,
  fetch_wr_if.queue  wr,
  output logic [1:0] read_valid_o,
  output T [1:0]     read_data_o
);

  // DEPTH is a power of two so pointers wrap on their own
  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  T     mem [DEPTH];
  ptr_t wr_ptr;
  ptr_t rd_ptr;
  cnt_t count;
  cnt_t wr_cnt;
  cnt_t rd_cnt;

  assign wr_cnt = wr.valid ? cnt_t'(wr.num) : '0;
  assign rd_cnt = cnt_t'(read_num_i);

  // Two free entries
  assign wr.ready = count <= cnt_t'(DEPTH - 2);

  assign read_valid_o[0] = count != '0;
  assign read_valid_o[1] = count > cnt_t'(1);
  assign read_data_o[0]  = mem[rd_ptr];
  assign read_data_o[1]  = mem[rd_ptr + ptr_t'(1)];

  always_ff @(posedge clk) begin
    if (wr.valid && !flush_i) begin
      if (wr.num != 2'd0) begin
        mem[wr_ptr] <= wr.data[0];
      end
      if (wr.num == 2'd2) begin
        mem[wr_ptr + ptr_t'(1)] <= wr.data[1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      wr_ptr <= wr_ptr + ptr_t'(wr_cnt);
      rd_ptr <= rd_ptr + ptr_t'(rd_cnt);
      count  <= count + wr_cnt - rd_cnt;
    end
  end

endmodule

// ==== verilog/decode_lane.sv ====
`timescale 1ns/1ps

module decode_lane import frontend_pkg::*; (
  input  fetch_entry_t  entry_i,
  output decoded_inst_t dec_o
);

  logic [31:0] inst;
  inst_class_t cls;
  logic        is_link;
  logic [1:0]  r0_sel;
  logic [1:0]  r1_sel;
  logic [1:0]  w_sel;
  logic [4:0]  r_reg0;
  logic [4:0]  r_reg1;
  logic [4:0]  w_reg;

  assign inst = entry_i.inst;
  assign cls  = inst_class_t'(inst[31:30]);

  // Port usage per class
  always_comb begin
    is_link = 1'b0;
    r0_sel  = R0_RD;
    r1_sel  = R1_RJ;
    w_sel   = W_NONE;
    case (cls)
      CLS_ALU_RR: begin
        r0_sel = R0_RK;
        w_sel  = W_RD;
      end
      CLS_ALU_RI: begin
        r0_sel = R0_NONE;
        w_sel  = W_RD;
      end
      CLS_BRANCH: begin
        if (inst[29]) begin
          is_link = 1'b1;
          r0_sel  = R0_NONE;
          r1_sel  = R1_NONE;
          w_sel   = W_LINK;
        end
      end
      default: begin
      end
    endcase
  end

  always_comb begin
    case (r0_sel)
      R0_RK:   r_reg0 = inst[14:10];
      R0_RD:   r_reg0 = inst[4:0];
      default: r_reg0 = '0;
    endcase
    case (r1_sel)
      R1_RJ:   r_reg1 = inst[9:5];
      default: r_reg1 = '0;
    endcase
    case (w_sel)
      W_RD:    w_reg = inst[4:0];
      // Link register is r1
      W_LINK:  w_reg = 5'd1;
      default: w_reg = '0;
    endcase
  end

  assign dec_o.pc      = entry_i.pc;
  assign dec_o.cls     = cls;
  assign dec_o.is_link = is_link;
  assign dec_o.r_reg0  = r_reg0;
  assign dec_o.r_reg1  = r_reg1;
  assign dec_o.w_reg   = w_reg;
  assign dec_o.imm     = inst[25:0];

endmodule

// ==== verilog/dispatch_buf.sv ====
`timescale 1ns/1ps

module dispatch_buf import frontend_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                flush_i,
  input  logic [1:0]          issue_i,
  input  logic [1:0]          lane_valid_i,
  input  decoded_inst_t [1:0] lane_dec_i,
  output logic [1:0]          read_num_o,
  output logic [1:0]          inst_valid_o,
  output decoded_inst_t [1:0] inst_o
);

  logic [1:0]          slot_valid;
  decoded_inst_t [1:0] slot;
  logic [1:0]          issued;
  logic [1:0]          have;
  logic [1:0]          keep;
  logic [1:0]          free;
  logic [1:0]          avail;
  logic [1:0]          take;
  logic [1:0]          nxt_valid;
  decoded_inst_t [1:0] nxt_slot;

  // Slot 1 only issues behind slot 0
  assign issued = (issue_i[0] && slot_valid[0]) ?
                  ((issue_i[1] && slot_valid[1]) ? 2'd2 : 2'd1) : 2'd0;
  assign have   = {1'b0, slot_valid[0]} + {1'b0, slot_valid[1]};
  assign keep   = have - issued;
  assign free   = 2'd2 - keep;
  assign avail  = {1'b0, lane_valid_i[0]} + {1'b0, lane_valid_i[1]};
  assign take   = (avail < free) ? avail : free;

  assign read_num_o   = take;
  assign inst_valid_o = slot_valid;
  assign inst_o       = slot;

  always_comb begin
    nxt_slot  = slot;
    nxt_valid = slot_valid;
    case (keep)
      2'd0: begin
        nxt_slot  = lane_dec_i;
        nxt_valid = (take == 2'd2) ? 2'b11 : {1'b0, take == 2'd1};
      end
      2'd1: begin
        // Leftover moves down, first lane entry fills behind it
        nxt_slot[0] = (issued == 2'd0) ? slot[0] : slot[1];
        nxt_slot[1] = lane_dec_i[0];
        nxt_valid   = (take != 2'd0) ? 2'b11 : 2'b01;
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    slot <= nxt_slot;
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush_i) begin
      slot_valid <= 2'b00;
    end else begin
      slot_valid <= nxt_valid;
    end
  end

endmodule

// ==== verilog/core_frontend.sv ====
`timescale 1ns/1ps

module core_frontend import frontend_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  // Instruction memory
  output logic                imem_req_o,
  output logic [31:0]         imem_addr_o,
  input  logic                imem_valid_i,
  input  logic [1:0][31:0]    imem_data_i,
  // Backend
  input  logic                redirect_i,
  input  logic [31:0]         redirect_pc_i,
  input  logic                wait_inst_i,
  input  logic                int_i,
  output logic [1:0]          inst_valid_o,
  output decoded_inst_t [1:0] inst_o,
  input  logic [1:0]          issue_i
);

  fetch_wr_if wr_if ();

  logic [1:0]          q_valid;
  fetch_entry_t [1:0]  q_data;
  logic [1:0]          read_num;
  decoded_inst_t [1:0] lane_dec;

  fetch_pc_gen u_pc_gen (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_i    (redirect_i),
    .redirect_pc_i (redirect_pc_i),
    .wait_inst_i   (wait_inst_i),
    .int_i         (int_i),
    .imem_valid_i  (imem_valid_i),
    .imem_data_i   (imem_data_i),
    .imem_req_o    (imem_req_o),
    .imem_addr_o   (imem_addr_o),
    .wr            (wr_if)
  );

  inst_queue #(
    .T     (fetch_entry_t),
    .DEPTH (QUEUE_DEPTH)
  ) u_queue (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i),
    .read_num_i   (read_num),
    .wr           (wr_if),
    .read_valid_o (q_valid),
    .read_data_o  (q_data)
  );

  for (genvar p = 0; p < 2; p++) begin : g_lane
    decode_lane u_lane (
      .entry_i (q_data[p]),
      .dec_o   (lane_dec[p])
    );
  end

  dispatch_buf u_dispatch (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (redirect_i),
    .issue_i      (issue_i),
    .lane_valid_i (q_valid),
    .lane_dec_i   (lane_dec),
    .read_num_o   (read_num),
    .inst_valid_o (inst_valid_o),
    .inst_o       (inst_o)
  );

endmodule

// ==== verif/core_frontend_chk.sv ====
`timescale 1ns/1ps

module core_frontend_chk import frontend_pkg::*; #(
  parameter int unsigned DEPTH = QUEUE_DEPTH
) (
  input logic                       clk,
  input logic                       rst_n,
  input logic                       flush_i,
  input logic                       wr_valid_i,
  input logic                       wr_ready_i,
  input logic [$clog2(DEPTH+1)-1:0] count_i,
  input logic [1:0]                 read_valid_i
);

  a_count_max: assert property (@(posedge clk) disable iff (!rst_n)
    32'(count_i) <= DEPTH)
    else $error("queue count %0d above depth", count_i);

  a_write_ready: assert property (@(posedge clk) disable iff (!rst_n)
    wr_valid_i |-> wr_ready_i)
    else $error("queue written while not ready");

  a_flush_empty: assert property (@(posedge clk) disable iff (!rst_n)
    flush_i |=> count_i == '0)
    else $error("queue count %0d after flush", count_i);

  // Head entries are valid in order
  a_valid_order: assert property (@(posedge clk) disable iff (!rst_n)
    read_valid_i[1] |-> read_valid_i[0])
    else $error("read_valid_o[1] set without read_valid_o[0]");

endmodule

// ==== verif/core_frontend_tb.sv ====
`timescale 1ns/1ps

module core_frontend_tb import frontend_pkg::*; ();

  logic                clk;
  logic                rst_n;
  logic                imem_req;
  logic [31:0]         imem_addr;
  logic                imem_valid;
  logic [1:0][31:0]    imem_data;
  logic                redirect;
  logic [31:0]         redirect_pc;
  logic                wait_inst;
  logic                irq;
  logic [1:0]          inst_valid;
  decoded_inst_t [1:0] inst_out;
  logic [1:0]          issue;

  logic [31:0] mem [256];
  logic [31:0] mem_addr;
  logic        mem_busy;
  int          mem_wait;
  logic [31:0] exp_pc;
  int unsigned model_cnt;
  int unsigned issued_cnt = 0;
  int unsigned planned = 40 + 300 + 8 * 30 + 80;

  core_frontend u_dut (
    .clk           (clk),
    .rst_n         (rst_n),
    .imem_req_o    (imem_req),
    .imem_addr_o   (imem_addr),
    .imem_valid_i  (imem_valid),
    .imem_data_i   (imem_data),
    .redirect_i    (redirect),
    .redirect_pc_i (redirect_pc),
    .wait_inst_i   (wait_inst),
    .int_i         (irq),
    .inst_valid_o  (inst_valid),
    .inst_o        (inst_out),
    .issue_i       (issue)
  );

  bind inst_queue core_frontend_chk #(.DEPTH(DEPTH)) u_chk (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush_i      (flush_i),
    .wr_valid_i   (wr.valid),
    .wr_ready_i   (wr.ready),
    .count_i      (count),
    .read_valid_i (read_valid_o)
  );

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1);
  endtask

  function automatic string fmt_inst(input decoded_inst_t d);
    return $sformatf("pc %h cls %h link %h r0 %h r1 %h w %h imm %h",
                     d.pc, d.cls, d.is_link, d.r_reg0, d.r_reg1, d.w_reg, d.imm);
  endfunction

  // Reference decode from the class table
  function automatic decoded_inst_t expect_decode(input logic [31:0] pc, input logic [31:0] w);
    decoded_inst_t d;
    d        = '0;
    d.pc     = pc;
    d.cls    = inst_class_t'(w[31:30]);
    d.imm    = w[25:0];
    d.r_reg1 = w[9:5];
    if (w[31:30] == 2'b00) begin
      d.r_reg0 = w[14:10];
      d.w_reg  = w[4:0];
    end else if (w[31:30] == 2'b01) begin
      d.w_reg = w[4:0];
    end else if (w[31:29] == 3'b111) begin
      d.r_reg1  = 5'd0;
      d.w_reg   = 5'd1;
      d.is_link = 1'b1;
    end else begin
      // Stores and plain branches read rd and rj
      d.r_reg0 = w[4:0];
    end
    return d;
  endfunction

  task automatic check_inst(input decoded_inst_t got, input decoded_inst_t exp, input int p);
    if (got !== exp) begin
      $display("** Error: inst_o[%0d] got      %s", p, fmt_inst(got));
      fail_run($sformatf("** Error: inst_o[%0d] expected %s", p, fmt_inst(exp)));
    end
  endtask

  task automatic check_count(input int unsigned got, input int unsigned exp, input string name);
    if (got !== exp) begin
      fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic take_slot(input int p);
    decoded_inst_t exp;
    exp = expect_decode(exp_pc, mem[exp_pc[9:2]]);
    check_inst(inst_out[p], exp, p);
    exp_pc = exp_pc + 32'd4;
    model_cnt++;
  endtask

  // One backend cycle with single-cycle strobes
  task automatic run_cycle(input int unsigned busy_pct);
    logic [1:0] iss;
    @(negedge clk);
    redirect  = 1'b0;
    wait_inst = 1'b0;
    irq       = 1'b0;
    iss = ($urandom_range(99) < busy_pct) ? 2'b00 : 2'($urandom_range(3));
    if (inst_valid[1] && !inst_valid[0]) begin
      fail_run("Slot 1 offered while slot 0 is empty");
    end
    if (iss[0] && inst_valid[0]) begin
      take_slot(0);
      if (iss[1] && inst_valid[1]) begin
        take_slot(1);
      end
    end
    issue = iss;
  endtask

  task automatic run_insts(input int unsigned n, input int unsigned busy_pct);
    int unsigned goal;
    goal = model_cnt + n;
    while (model_cnt < goal) begin
      // Long stall lets the queue fill up
      if ($urandom_range(63) == 0) begin
        repeat (40) run_cycle(100);
      end
      run_cycle(busy_pct);
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Instructions the DUT accepts at each edge
  always @(posedge clk) begin
    if (rst_n && issue[0] && inst_valid[0]) begin
      issued_cnt <= issued_cnt + ((issue[1] && inst_valid[1]) ? 2 : 1);
    end
  end

  // Memory model with one outstanding request
  initial begin
    imem_valid = 1'b0;
    imem_data  = '0;
    mem_busy   = 1'b0;
    forever begin
      @(negedge clk);
      imem_valid = 1'b0;
      if (mem_busy) begin
        mem_wait--;
        if (mem_wait == 0) begin
          imem_valid   = 1'b1;
          imem_data[0] = mem[{mem_addr[9:3], 1'b0}];
          imem_data[1] = mem[{mem_addr[9:3], 1'b1}];
          mem_busy     = 1'b0;
        end
      end
      if (imem_req === 1'b1) begin
        if (mem_busy) begin
          fail_run("Memory request made while another one is outstanding");
        end
        if (imem_addr[2:0] != 3'd0) begin
          fail_run($sformatf("** Error: imem_addr_o got %h, not 8-byte aligned", imem_addr));
        end
        mem_addr = imem_addr;
        mem_wait = 1 + int'($urandom_range(3));
        mem_busy = 1'b1;
      end
    end
  end

  initial begin
    repeat (planned * 40 + 2000) @(posedge clk);
    fail_run($sformatf("Timeout, only %0d of %0d instructions issued", model_cnt, planned));
  end

  initial begin
    logic [31:0] tgt;
    logic        resumed;
    void'($urandom(32'ha5efefa8));
    rst_n       = 1'b0;
    redirect    = 1'b0;
    redirect_pc = '0;
    wait_inst   = 1'b0;
    irq         = 1'b0;
    issue       = 2'b00;
    exp_pc      = RESET_PC;
    model_cnt   = 0;
    for (int i = 0; i < 256; i++) begin
      mem[i] = $urandom;
    end
    // First words hit every class and both branch forms
    for (int i = 0; i < 5; i++) begin
      mem[i][31:29] = (i == 4) ? 3'b110 : {i[1:0], 1'b1};
    end
    repeat (16) @(negedge clk);
    if (imem_req !== 1'b0 || inst_valid !== 2'b00 || u_dut.u_queue.count !== '0) begin
      fail_run("Request, valid or queue count not cleared by reset");
    end
    rst_n = 1'b1;
    run_cycle(100);
    if (imem_req !== 1'b1) begin
      fail_run("No fetch request in the cycle after reset release");
    end
    run_insts(40, 0);
    run_insts(300, 50);
    for (int r = 0; r < 8; r++) begin
      tgt = $urandom & 32'hffff_fffc;
      tgt[2] = r[0];
      repeat ($urandom_range(6)) run_cycle(50);
      run_cycle(100);
      redirect    = 1'b1;
      redirect_pc = tgt;
      exp_pc      = tgt;
      run_insts(30, 40);
    end
    // Idle lock
    run_cycle(30);
    wait_inst = 1'b1;
    run_cycle(30);
    repeat (60) begin
      run_cycle(30);
      if (imem_req !== 1'b0) begin
        fail_run("Fetch request made while the idle lock is set");
      end
    end
    run_cycle(30);
    irq = 1'b1;
    resumed = 1'b0;
    repeat (20) begin
      run_cycle(30);
      resumed = resumed | (imem_req === 1'b1);
    end
    if (!resumed) begin
      fail_run("Fetch did not resume after the interrupt");
    end
    run_insts(80, 30);
    // Last issue reaches the DUT at the next edge
    run_cycle(100);
    check_count(issued_cnt, model_cnt, "issued instruction count");
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== core_frontend.f ====
verilog/frontend_pkg.sv
verilog/fetch_wr_if.sv
verilog/fetch_pc_gen.sv
verilog/inst_queue.sv
verilog/decode_lane.sv
verilog/dispatch_buf.sv
verilog/core_frontend.sv
verif/core_frontend_chk.sv
verif/core_frontend_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= core_frontend_tb
RTL_TOP   ?= core_frontend
FILELIST  ?= core_frontend.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing --assert

SRCS := $(shell cat $(FILELIST))
SIM  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run lint clean

all: run

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
